/* bitStreamIf.sv */
//**************************************
// bit stream link between word fetcher
// and frame parser
//**************************************
`timescale 1ns/1ps
`default_nettype none

interface bitStreamIf;

  mp3SyncPkg::parseStateT parseState;
  // level, high while the parser wants input
  logic                   bitReq;
  // one strobe per bit, or per byte in main data
  logic                   bitValid;
  logic                   bitData;
  logic [7:0]             byteData;

  modport fetch (
    input  parseState,
    input  bitReq,
    output bitValid,
    output bitData,
    output byteData
  );

  modport parse (
    output parseState,
    output bitReq,
    input  bitValid,
    input  bitData,
    input  byteData
  );

endinterface

`default_nettype wire

/* files.f */
mp3SyncPkg.sv
bitStreamIf.sv
wordFetch.sv
frameParser.sv
mainDataWriter.sv
mp3Sync.sv
tbMp3Sync.sv

/* frameParser.sv */
//**************************************
// frame parser
// sync search, header capture, crc and
// side info skip, main data byte count
// and format checks
//**************************************
`timescale 1ns/1ps
`default_nettype none

module frameParser #(
  parameter logic [11:0] SyncTimeoutWords = 12'd4094
) (
  input  wire logic  Clk,
  input  wire logic  reset,
  input  wire logic  enable,
  input  wire logic  wordLoaded,
  bitStreamIf.parse  bs,
  output logic       byteWrite,
  output logic [7:0] byteData,
  output logic [1:0] mode,
  output logic [1:0] modeExt,
  output logic [1:0] sampleRate,
  output logic [3:0] bitrate,
  output logic       invalidFormat,
  output logic       done
);

  mp3SyncPkg::parseStateT state;
  mp3SyncPkg::parseStateT nextState;
  logic [14:0]            syncReg;
  logic [16:0]            headReg;
  logic [8:0]             bitCnt;
  logic [10:0]            byteCnt;
  logic [11:0]            wordCnt;
  logic                   mono;
  logic [8:0]             sideLen;
  logic [10:0]            mainLen;

  assign mono    = (headReg[7:6] == 2'b11);
  assign sideLen = mono ? mp3SyncPkg::SideLenMono : mp3SyncPkg::SideLenStereo;
  assign mainLen = mp3SyncPkg::mainDataLen(headReg[15:12], headReg[11:10], headReg[9],
                                           headReg[16], mono);

  //**************************************
  // frame state machine
  //**************************************
  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= mp3SyncPkg::Null;
    end else begin
      state <= nextState;
    end
  end

  // request drops on the cycle the count for the state is complete
  always_comb begin
    case (state)
      mp3SyncPkg::Sync: bs.bitReq = (syncReg != mp3SyncPkg::SyncWord);
      mp3SyncPkg::Head: bs.bitReq = (bitCnt != 9'd17);
      // protection bit set means no crc word
      mp3SyncPkg::Crc:  bs.bitReq = (bitCnt != 9'd16) && !headReg[16];
      mp3SyncPkg::Side: bs.bitReq = (bitCnt != sideLen);
      mp3SyncPkg::Main: bs.bitReq = (byteCnt != mainLen);
      default:          bs.bitReq = 1'b0;
    endcase
  end

  always_comb begin
    nextState = state;
    case (state)
      mp3SyncPkg::Null: begin
        if (enable && !done) begin
          nextState = mp3SyncPkg::Sync;
        end
      end
      mp3SyncPkg::Sync: nextState = bs.bitReq ? state : mp3SyncPkg::Head;
      mp3SyncPkg::Head: nextState = bs.bitReq ? state : mp3SyncPkg::Crc;
      mp3SyncPkg::Crc:  nextState = bs.bitReq ? state : mp3SyncPkg::Side;
      mp3SyncPkg::Side: nextState = bs.bitReq ? state : mp3SyncPkg::Main;
      mp3SyncPkg::Main: nextState = bs.bitReq ? state : mp3SyncPkg::Read;
      default:          nextState = mp3SyncPkg::Null;
    endcase
  end

  assign bs.parseState = state;

  always_ff @(posedge Clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= (state == mp3SyncPkg::Read);
    end
  end

  // bit count for head, crc and side; byte count for main
  always_ff @(posedge Clk) begin
    if (reset || !bs.bitReq) begin
      bitCnt  <= 9'd0;
      byteCnt <= 11'd0;
    end else if (bs.bitValid) begin
      if (state == mp3SyncPkg::Main) begin
        byteCnt <= byteCnt + 11'd1;
      end else if (state != mp3SyncPkg::Sync) begin
        bitCnt <= bitCnt + 9'd1;
      end
    end
  end

  always_ff @(posedge Clk) begin
    if (reset || state == mp3SyncPkg::Null) begin
      syncReg <= 15'd0;
    end else if (state == mp3SyncPkg::Sync && bs.bitValid) begin
      syncReg <= {syncReg[13:0], bs.bitData};
    end
  end

  always_ff @(posedge Clk) begin
    if (state == mp3SyncPkg::Head && bs.bitValid) begin
      headReg <= {headReg[15:0], bs.bitData};
    end
  end

  assign bitrate    = headReg[15:12];
  assign sampleRate = headReg[11:10];
  assign mode       = headReg[7:6];
  assign modeExt    = headReg[5:4];

  assign byteWrite = (state == mp3SyncPkg::Main) && bs.bitValid;
  assign byteData  = bs.byteData;

  //**************************************
  // format checks
  //**************************************
  // words fetched in the current sync search
  always_ff @(posedge Clk) begin
    if (reset || state == mp3SyncPkg::Null) begin
      wordCnt <= 12'd0;
    end else if (state == mp3SyncPkg::Sync && wordLoaded && wordCnt != SyncTimeoutWords) begin
      wordCnt <= wordCnt + 12'd1;
    end
  end

  // sticky until reset; joint stereo with intensity is not supported
  always_ff @(posedge Clk) begin
    if (reset) begin
      invalidFormat <= 1'b0;
    end else if (wordCnt == SyncTimeoutWords ||
                 (state == mp3SyncPkg::Main && mode == 2'd1 && modeExt[0])) begin
      invalidFormat <= 1'b1;
    end
  end

  // one strobe per main data byte
  assert property (@(posedge Clk) disable iff (reset)
                   (state == mp3SyncPkg::Main && bs.bitValid) |=> !bs.bitValid);

endmodule

`default_nettype wire

/* mainDataWriter.sv */
//**************************************
// main data writer
// ram address counter, registered write
//**************************************
`timescale 1ns/1ps
`default_nettype none

module mainDataWriter #(
  parameter int RamAddrWidth = 11
) (
  input  wire logic               Clk,
  input  wire logic               reset,
  input  wire logic               byteWrite,
  input  wire logic [7:0]         byteData,
  output logic                    ramWe,
  output logic [RamAddrWidth-1:0] ramAddr,
  output logic [7:0]              ramData
);

  // next free location, runs on across frames
  logic [RamAddrWidth-1:0] writeAddr;

  always_ff @(posedge Clk) begin
    if (reset) begin
      writeAddr <= '0;
      ramAddr   <= '0;
      ramWe     <= 1'b0;
    end else begin
      ramWe   <= byteWrite;
      ramAddr <= writeAddr;
      if (byteWrite) begin
        writeAddr <= writeAddr + 1'b1;
      end
    end
  end

  always_ff @(posedge Clk) begin
    if (byteWrite) begin
      ramData <= byteData;
    end
  end

endmodule

`default_nettype wire

/* mp3Sync.sv */
//**************************************
// mp3 layer III frame synchronizer top
// fetcher, parser and ram writer
//**************************************
`timescale 1ns/1ps
`default_nettype none

module mp3Sync #(
  parameter logic [11:0] SyncTimeoutWords = 12'd4094,
  parameter int          RamAddrWidth     = 11
) (
  input  wire logic                    Clk,
  input  wire logic                    reset,
  input  wire logic                    enable,
  input  wire logic                    fifoEmpty,
  input  wire logic [31:0]             fifoData,
  output logic                         fifoRen,
  output logic                         ramWe,
  output logic [RamAddrWidth-1:0]      ramAddr,
  output logic [7:0]                   ramData,
  output logic                         done,
  output logic                         invalidFormat,
  output logic [1:0]                   mode,
  output logic [1:0]                   modeExt,
  output logic [1:0]                   sampleRate,
  output logic [3:0]                   bitrate
);

  logic       wordLoaded;
  logic       byteWrite;
  logic [7:0] byteData;

  bitStreamIf bs();

  wordFetch uFetch (
    .Clk        (Clk),
    .reset      (reset),
    .enable     (enable),
    .done       (done),
    .fifoEmpty  (fifoEmpty),
    .fifoData   (fifoData),
    .fifoRen    (fifoRen),
    .wordLoaded (wordLoaded),
    .bs         (bs.fetch)
  );

  frameParser #(
    .SyncTimeoutWords (SyncTimeoutWords)
  ) uParser (
    .Clk           (Clk),
    .reset         (reset),
    .enable        (enable),
    .wordLoaded    (wordLoaded),
    .bs            (bs.parse),
    .byteWrite     (byteWrite),
    .byteData      (byteData),
    .mode          (mode),
    .modeExt       (modeExt),
    .sampleRate    (sampleRate),
    .bitrate       (bitrate),
    .invalidFormat (invalidFormat),
    .done          (done)
  );

  mainDataWriter #(
    .RamAddrWidth (RamAddrWidth)
  ) uWriter (
    .Clk       (Clk),
    .reset     (reset),
    .byteWrite (byteWrite),
    .byteData  (byteData),
    .ramWe     (ramWe),
    .ramAddr   (ramAddr),
    .ramData   (ramData)
  );

endmodule

`default_nettype wire

/* mp3SyncPkg.sv */
//**************************************
// shared definitions for the frame sync
// parser and fetch state enums
// sync word and side info lengths
// main data length table
//**************************************
`default_nettype none

package mp3SyncPkg;

  typedef enum logic [2:0] {
    Null,
    Sync,
    Head,
    Crc,
    Side,
    Main,
    Read
  } parseStateT;

  typedef enum logic [2:0] {
    Idle,
    Comp,
    Requ,
    Dout,
    Done
  } fetchStateT;

  // 12 ones, id bit, layer III
  localparam logic [14:0] SyncWord = 15'h7FFD;

  localparam logic [8:0] SideLenMono   = 9'd136;
  localparam logic [8:0] SideLenStereo = 9'd256;

  // main data bytes left in the frame after header, crc and side info
  function automatic logic [10:0] mainDataLen(
    input logic [3:0] bitrateIdx,
    input logic [1:0] sampleIdx,
    input logic       padding,
    input logic       protection,
    input logic       mono
  );
    logic [32:0] lens;
    logic [10:0] base;
    // packed as {44.1k, 48k, 32k}
    case (bitrateIdx)
      4'd1:    lens = {11'd65, 11'd57, 11'd105};
      4'd2:    lens = {11'd91, 11'd81, 11'd141};
      4'd3:    lens = {11'd117, 11'd105, 11'd177};
      4'd4:    lens = {11'd143, 11'd129, 11'd213};
      4'd5:    lens = {11'd169, 11'd153, 11'd249};
      4'd6:    lens = {11'd222, 11'd201, 11'd321};
      4'd7:    lens = {11'd274, 11'd249, 11'd393};
      4'd8:    lens = {11'd326, 11'd297, 11'd465};
      4'd9:    lens = {11'd378, 11'd345, 11'd537};
      4'd10:   lens = {11'd483, 11'd441, 11'd681};
      4'd11:   lens = {11'd587, 11'd537, 11'd825};
      4'd12:   lens = {11'd692, 11'd633, 11'd969};
      4'd13:   lens = {11'd796, 11'd729, 11'd1113};
      default: lens = {11'd1005, 11'd921, 11'd1401};
    endcase
    case (sampleIdx)
      2'd0:    base = lens[32:22];
      2'd1:    base = lens[21:11];
      default: base = lens[10:0];
    endcase
    // mono side info is 15 bytes shorter, no crc adds 2
    return base + (mono ? 11'd15 : 11'd0) + (protection ? 11'd2 : 11'd0) + 11'd1 +
           {10'd0, padding};
  endfunction

endpackage

`default_nettype wire

/* runSim.sh */
#!/bin/sh
# build and run the frame sync testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f files.f --top-module tbMp3Sync \
  -Mdir obj_dir -o tbMp3Sync
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tbMp3Sync > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0

/* tbMp3Sync.sv */
//****************************************
// testbench for the frame synchronizer
// frame builder, fifo model, ram model,
// watchdog and directed tests
//****************************************
`timescale 1ns/1ps
`default_nettype none

module tbMp3Sync;

  localparam int CyclesPerByte = 40;

  logic        Clk = 1'b0;
  logic        reset = 1'b1;
  logic        enable = 1'b0;
  logic        fifoEmpty = 1'b1;
  logic [31:0] fifoData = 32'd0;
  logic        fifoRen;
  logic        ramWe;
  logic [10:0] ramAddr;
  logic [7:0]  ramData;
  logic        done;
  logic        invalidFormat;
  logic [1:0]  mode;
  logic [1:0]  modeExt;
  logic [1:0]  sampleRate;
  logic [3:0]  bitrate;

  logic [31:0] fifoQ[$];
  logic [31:0] wrAddrQ[$];
  logic [31:0] wrDataQ[$];
  logic [7:0]  expMain[$];
  logic [31:0] dataLfsr = 32'h538;
  logic [31:0] gapLfsr = 32'h538;
  logic        stallOn = 1'b0;
  int          cycleCnt = 0;
  int          deadline = 1000;
  int          doneCnt = 0;
  int          errCnt = 0;
  int          testErr = 0;
  int          testCnt = 0;

  mp3Sync #(
    .SyncTimeoutWords (12'd16)
  ) DUT (
    .Clk           (Clk),
    .reset         (reset),
    .enable        (enable),
    .fifoEmpty     (fifoEmpty),
    .fifoData      (fifoData),
    .fifoRen       (fifoRen),
    .ramWe         (ramWe),
    .ramAddr       (ramAddr),
    .ramData       (ramData),
    .done          (done),
    .invalidFormat (invalidFormat),
    .mode          (mode),
    .modeExt       (modeExt),
    .sampleRate    (sampleRate),
    .bitrate       (bitrate)
  );

  always #50 Clk = ~Clk;

  //****************************************
  // fifo model, ram model, watchdog
  //****************************************
  // data one cycle after the read strobe
  always @(posedge Clk) begin
    gapLfsr = lfsrStep(gapLfsr);
    if (fifoRen && fifoQ.size() != 0) begin
      fifoData <= fifoQ.pop_front();
    end
    fifoEmpty <= (fifoQ.size() == 0) || (stallOn && gapLfsr[0]);
  end

  always @(posedge Clk) begin
    if (ramWe) begin
      wrAddrQ.push_back({21'd0, ramAddr});
      wrDataQ.push_back({24'd0, ramData});
    end
    if (done) begin
      doneCnt <= doneCnt + 1;
    end
  end

  always @(posedge Clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt > deadline) begin
      $display("timeout: the DUT did not finish the test within its cycle limit");
      $display("TEST FAIL");
      $finish;
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randByte(output logic [7:0] b);
    b = 8'd0;
    for (int i = 0; i < 8; i++) begin
      dataLfsr = lfsrStep(dataLfsr);
      b = {b[6:0], dataLfsr[0]};
    end
  endtask

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errCnt++;
      testErr++;
    end
  endtask

  task automatic reportTest(input string name);
    testCnt++;
    $display("test %s: %0d errors", name, testErr);
    testErr = 0;
  endtask

  task automatic armTimeout(input int nBytes);
    deadline = cycleCnt + nBytes * CyclesPerByte + 200;
  endtask

  task automatic applyReset();
    @(negedge Clk);
    fifoQ.delete();
    wrAddrQ.delete();
    wrDataQ.delete();
    stallOn = 1'b0;
    @(posedge Clk);
    reset  <= 1'b1;
    enable <= 1'b0;
    repeat (2) @(posedge Clk);
    reset <= 1'b0;
  endtask

  // junk, header, optional crc, side info, main data, zero fill to a word
  task automatic buildFrame(input int junkBytes, input logic prot, input logic [3:0] rateIdx,
                            input logic [1:0] sampIdx, input logic pad,
                            input logic [1:0] frMode, input logic [1:0] frModeExt,
                            input int mainBytes);
    logic [7:0]  bytes[$];
    logic [7:0]  b;
    logic [31:0] head;
    int          sideBytes;
    head = {mp3SyncPkg::SyncWord, prot, rateIdx, sampIdx, pad, 1'b0, frMode, frModeExt, 4'd0};
    sideBytes = (frMode == 2'd3) ? mp3SyncPkg::SideLenMono / 8 : mp3SyncPkg::SideLenStereo / 8;
    expMain.delete();
    for (int i = 0; i < junkBytes; i++) begin
      randByte(b);
      // a zero in every byte keeps the sync pattern out of the junk
      bytes.push_back(b & 8'hEF);
    end
    for (int i = 3; i >= 0; i--) begin
      bytes.push_back(head[i*8 +: 8]);
    end
    for (int i = 0; i < (prot ? 0 : 2) + sideBytes; i++) begin
      randByte(b);
      bytes.push_back(b);
    end
    for (int i = 0; i < mainBytes; i++) begin
      randByte(b);
      bytes.push_back(b);
      expMain.push_back(b);
    end
    while (bytes.size() % 4 != 0) begin
      bytes.push_back(8'h00);
    end
    @(negedge Clk);
    for (int i = 0; i < bytes.size(); i += 4) begin
      fifoQ.push_back({bytes[i], bytes[i+1], bytes[i+2], bytes[i+3]});
    end
    armTimeout(bytes.size());
  endtask

  task automatic waitDone(input int startDone);
    while (doneCnt == startDone) begin
      @(negedge Clk);
    end
    repeat (10) @(negedge Clk);
  endtask

  task automatic checkHeader(input logic [1:0] expMode, input logic [1:0] expExt,
                             input logic [1:0] expSamp, input logic [3:0] expRate);
    checkVal("mode", mode, expMode);
    checkVal("modeExt", modeExt, expExt);
    checkVal("sampleRate", sampleRate, expSamp);
    checkVal("bitrate", bitrate, expRate);
  endtask

  task automatic checkRam(input int firstAddr);
    checkVal("ramWriteCount", wrAddrQ.size(), expMain.size());
    for (int i = 0; i < wrAddrQ.size() && i < expMain.size(); i++) begin
      checkVal("ramAddr", wrAddrQ[i], (firstAddr + i) % 2048);
      checkVal("ramData", wrDataQ[i], expMain[i]);
    end
  endtask

  //****************************************
  // directed tests
  //****************************************
  task automatic resetValuesTest();
    applyReset();
    @(negedge Clk);
    checkVal("fifoRen", fifoRen, 0);
    checkVal("ramWe", ramWe, 0);
    checkVal("done", done, 0);
    checkVal("invalidFormat", invalidFormat, 0);
    checkVal("ramAddr", ramAddr, 0);
    reportTest("reset values");
  endtask

  // mono, no crc: 57 + 15 + 2 + 1 bytes of main data
  task automatic monoFrameTest(input logic stall, input string name);
    int startDone;
    applyReset();
    dataLfsr = 32'h538;
    buildFrame(3, 1'b1, 4'd1, 2'd1, 1'b0, 2'd3, 2'd0, 75);
    stallOn = stall;
    startDone = doneCnt;
    @(posedge Clk);
    enable <= 1'b1;
    waitDone(startDone);
    checkHeader(2'd3, 2'd0, 2'd1, 4'd1);
    checkRam(0);
    checkVal("doneCount", doneCnt - startDone, 1);
    checkVal("invalidFormat", invalidFormat, 0);
    reportTest(name);
  endtask

  // stereo with crc and padding: 65 + 1 + 1, runs on from the mono frame
  task automatic stereoCrcTest();
    int startDone;
    @(negedge Clk);
    wrAddrQ.delete();
    wrDataQ.delete();
    buildFrame(0, 1'b0, 4'd1, 2'd0, 1'b1, 2'd0, 2'd0, 67);
    startDone = doneCnt;
    waitDone(startDone);
    checkHeader(2'd0, 2'd0, 2'd0, 4'd1);
    checkRam(75);
    checkVal("doneCount", doneCnt - startDone, 1);
    reportTest("stereo crc frame");
  endtask

  task automatic intensityTest();
    int   startDone;
    logic seen;
    applyReset();
    buildFrame(2, 1'b1, 4'd1, 2'd1, 1'b0, 2'd1, 2'd1, 60);
    startDone = doneCnt;
    seen = 1'b0;
    @(posedge Clk);
    enable <= 1'b1;
    while (doneCnt == startDone) begin
      @(negedge Clk);
      if (seen) begin
        checkVal("invalidFormat", invalidFormat, 1);
      end
      seen = seen | invalidFormat;
    end
    repeat (20) begin
      @(negedge Clk);
      checkVal("invalidFormat", invalidFormat, 1);
    end
    checkVal("mode", mode, 2'd1);
    checkVal("modeExt", modeExt, 2'd1);
    reportTest("joint stereo intensity");
  endtask

  task automatic syncTimeoutTest();
    int          startDone;
    logic [7:0]  b;
    logic [31:0] w;
    applyReset();
    armTimeout(80);
    @(negedge Clk);
    // flag and address left set by the intensity frame
    checkVal("invalidFormat", invalidFormat, 0);
    checkVal("ramAddr", ramAddr, 0);
    w = 32'd0;
    for (int i = 0; i < 20; i++) begin
      for (int k = 0; k < 4; k++) begin
        randByte(b);
        w = {w[23:0], b & 8'hEF};
      end
      fifoQ.push_back(w);
    end
    startDone = doneCnt;
    @(posedge Clk);
    enable <= 1'b1;
    while (!invalidFormat) begin
      @(negedge Clk);
    end
    while (fifoQ.size() != 0) begin
      @(negedge Clk);
    end
    repeat (30) @(negedge Clk);
    checkVal("ramWriteCount", wrAddrQ.size(), 0);
    checkVal("doneCount", doneCnt - startDone, 0);
    checkVal("invalidFormat", invalidFormat, 1);
    reportTest("sync timeout");
  endtask

  initial begin
    resetValuesTest();
    monoFrameTest(1'b0, "mono frame");
    stereoCrcTest();
    monoFrameTest(1'b1, "mono frame with stalls");
    intensityTest();
    syncTimeoutTest();
    $display("tests %0d, errors %0d", testCnt, errCnt);
    if (errCnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* wordFetch.sv */
//**************************************
// word fetcher
// fifo read, word register, byte select
// and msb first bit serializer
//**************************************
`timescale 1ns/1ps
`default_nettype none

module wordFetch (
  input  wire logic        Clk,
  input  wire logic        reset,
  input  wire logic        enable,
  input  wire logic        done,
  input  wire logic        fifoEmpty,
  input  wire logic [31:0] fifoData,
  output logic             fifoRen,
  output logic             wordLoaded,
  bitStreamIf.fetch        bs
);

  mp3SyncPkg::fetchStateT state;
  mp3SyncPkg::fetchStateT nextState;
  logic [31:0]            wordReg;
  logic [2:0]             bytePtr;
  logic [2:0]             bitCnt;
  logic [7:0]             curByte;
  logic                   inMain;

  assign inMain = (bs.parseState == mp3SyncPkg::Main);

  //**************************************
  // fetch state machine
  //**************************************
  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= mp3SyncPkg::Idle;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      mp3SyncPkg::Idle: begin
        if (enable && !done && bs.parseState != mp3SyncPkg::Read) begin
          nextState = mp3SyncPkg::Comp;
        end
      end
      // pointer at 4 means the word is used up
      mp3SyncPkg::Comp: nextState = bytePtr[2] ? mp3SyncPkg::Requ : mp3SyncPkg::Dout;
      mp3SyncPkg::Requ: begin
        if (wordLoaded) begin
          nextState = mp3SyncPkg::Comp;
        end
      end
      mp3SyncPkg::Dout: begin
        if (bs.bitReq && (inMain || bitCnt == 3'd7)) begin
          nextState = mp3SyncPkg::Done;
        end
      end
      default: nextState = mp3SyncPkg::Idle;
    endcase
  end

  // one read in flight at a time
  assign fifoRen = (state == mp3SyncPkg::Requ) && !fifoEmpty && !wordLoaded;

  always_ff @(posedge Clk) begin
    if (reset) begin
      wordLoaded <= 1'b0;
    end else begin
      wordLoaded <= fifoRen;
    end
  end

  always_ff @(posedge Clk) begin
    if (wordLoaded) begin
      wordReg <= fifoData;
    end
  end

  always_ff @(posedge Clk) begin
    if (reset) begin
      bytePtr <= 3'd4;
    end else if (wordLoaded) begin
      bytePtr <= 3'd0;
    end else if (state == mp3SyncPkg::Done) begin
      bytePtr <= bytePtr + 3'd1;
    end
  end

  // msb byte first
  always_comb begin
    case (bytePtr[1:0])
      2'd0:    curByte = wordReg[31:24];
      2'd1:    curByte = wordReg[23:16];
      2'd2:    curByte = wordReg[15:8];
      default: curByte = wordReg[7:0];
    endcase
  end

  always_ff @(posedge Clk) begin
    if (reset || state == mp3SyncPkg::Requ || bs.parseState == mp3SyncPkg::Null) begin
      bitCnt <= 3'd0;
    end else if (state == mp3SyncPkg::Dout && bs.bitReq && !inMain) begin
      bitCnt <= bitCnt + 3'd1;
    end
  end

  assign bs.bitValid = (state == mp3SyncPkg::Dout) && bs.bitReq;
  assign bs.bitData  = curByte[3'd7 - bitCnt];
  assign bs.byteData = curByte;

  // fetch only once the current word is used up
  assert property (@(posedge Clk) disable iff (reset) fifoRen |-> bytePtr == 3'd4);

endmodule

`default_nettype wire
